// File: project.f
isa_pkg.sv
ctrl_pkg.sv
inst_decoder.sv
reg_file.sv
id_ex_buffer.sv
alu_execute.sv
pipe_top.sv
pipe_checker.sv
pipe_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module pipe_tb -f project.f -o pipe_sim \
  > build.log 2>&1 && ./obj_dir/pipe_sim > sim.log 2>&1 || echo "=== FAIL ===" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

// File: pipe_tb.sv
module pipe_tb;

  localparam int RESET_CYCLES = 16;
  localparam int PIPE_DEPTH   = 2;   // inst_valid edge to wb_valid
  localparam int RANDOM_SEED  = 77;
  localparam isa_pkg::op1_t OP1_UNUSED = 6'b111111;

  logic            clk;
  logic            reset;
  logic            inst_valid;
  isa_pkg::word_t  inst;
  logic            wb_valid;
  isa_pkg::regno_t wb_regno;
  isa_pkg::word_t  wb_data;

  // Stimulus and expected write-back per cycle
  string           row_name[$];
  logic            row_valid[$];
  isa_pkg::word_t  row_inst[$];
  logic            row_wb[$];
  isa_pkg::regno_t row_reg[$];
  isa_pkg::word_t  row_data[$];

  int num_rows    = 0;
  int cycle_count = 0;

  pipe_top #(
    .DMEM_ADDR_BITS (10)
  ) i_pipe_top (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb_valid   (wb_valid),
    .wb_regno   (wb_regno),
    .wb_data    (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > num_rows + RESET_CYCLES + 10) begin
      $display("Timeout: the run did not finish after %0d cycles", cycle_count);
      $display("=== FAIL ===");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  function automatic isa_pkg::word_t enc_alur(input isa_pkg::op2_t op2,
                                              input isa_pkg::regno_t rd,
                                              input isa_pkg::regno_t rs,
                                              input isa_pkg::regno_t rt);
    isa_pkg::word_t w;
    w = '0;
    w[isa_pkg::OP1_HI:isa_pkg::OP1_LO] = isa_pkg::OP1_ALUR;
    w[isa_pkg::OP2_HI:isa_pkg::OP2_LO] = op2;
    w[isa_pkg::RD_HI:isa_pkg::RD_LO]   = rd;
    w[isa_pkg::RS_HI:isa_pkg::RS_LO]   = rs;
    w[isa_pkg::RT_HI:isa_pkg::RT_LO]   = rt;
    return w;
  endfunction

  function automatic isa_pkg::word_t enc_imm(input isa_pkg::op1_t op1,
                                             input isa_pkg::regno_t rt,
                                             input isa_pkg::regno_t rs,
                                             input isa_pkg::imm_t imm);
    isa_pkg::word_t w;
    w = '0;
    w[isa_pkg::OP1_HI:isa_pkg::OP1_LO] = op1;
    w[isa_pkg::IMM_HI:isa_pkg::IMM_LO] = imm;  // Also covers op2 and rd bits
    w[isa_pkg::RS_HI:isa_pkg::RS_LO]   = rs;
    w[isa_pkg::RT_HI:isa_pkg::RT_LO]   = rt;
    return w;
  endfunction

  task automatic add_row(input string name, input logic valid, input isa_pkg::word_t word,
                         input logic wb, input isa_pkg::regno_t regno,
                         input isa_pkg::word_t data);
    row_name.push_back(name);
    row_valid.push_back(valid);
    row_inst.push_back(word);
    row_wb.push_back(wb);
    row_reg.push_back(regno);
    row_data.push_back(data);
  endtask

  // Immediate or load writing rt
  task automatic imm_row(input string name, input isa_pkg::op1_t op1,
                         input isa_pkg::regno_t rt, input isa_pkg::regno_t rs,
                         input isa_pkg::imm_t imm, input isa_pkg::word_t data);
    add_row(name, 1'b1, enc_imm(op1, rt, rs, imm), 1'b1, rt, data);
  endtask

  task automatic alur_row(input string name, input isa_pkg::op2_t op2,
                          input isa_pkg::regno_t rd, input isa_pkg::regno_t rs,
                          input isa_pkg::regno_t rt, input isa_pkg::word_t data);
    add_row(name, 1'b1, enc_alur(op2, rd, rs, rt), 1'b1, rd, data);
  endtask

  task automatic idle_row(input string name);
    add_row(name, 1'b0, $urandom(), 1'b0, 4'd0, 32'h0);  // Random word with valid low
  endtask

  task automatic build_table();
    imm_row("addi_neg", isa_pkg::OP1_ADDI, 4'd1, 4'd0, 16'hFFFB, 32'hFFFF_FFFB);
    imm_row("addi_r2", isa_pkg::OP1_ADDI, 4'd2, 4'd0, 16'h1234, 32'h0000_1234);
    imm_row("addi_r3", isa_pkg::OP1_ADDI, 4'd3, 4'd0, 16'h7F0F, 32'h0000_7F0F);
    imm_row("andi", isa_pkg::OP1_ANDI, 4'd4, 4'd1, 16'h00F0, 32'h0000_00F0);
    imm_row("ori", isa_pkg::OP1_ORI, 4'd5, 4'd2, 16'h8001, 32'hFFFF_9235);
    imm_row("xori", isa_pkg::OP1_XORI, 4'd6, 4'd3, 16'h00FF, 32'h0000_7FF0);
    idle_row("idle_1");
    alur_row("add", isa_pkg::OP2_ADD, 4'd7, 4'd2, 4'd3, 32'h0000_9143);
    alur_row("sub", isa_pkg::OP2_SUB, 4'd8, 4'd2, 4'd3, 32'hFFFF_9325);
    alur_row("and", isa_pkg::OP2_AND, 4'd9, 4'd5, 4'd6, 32'h0000_1230);
    alur_row("or", isa_pkg::OP2_OR, 4'd10, 4'd4, 4'd2, 32'h0000_12F4);
    alur_row("xor", isa_pkg::OP2_XOR, 4'd11, 4'd1, 4'd2, 32'hFFFF_EDCF);
    alur_row("nand", isa_pkg::OP2_NAND, 4'd12, 4'd2, 4'd3, 32'hFFFF_EDFB);
    alur_row("nor", isa_pkg::OP2_NOR, 4'd13, 4'd2, 4'd4, 32'hFFFF_ED0B);
    alur_row("nxor", isa_pkg::OP2_NXOR, 4'd14, 4'd2, 4'd3, 32'hFFFF_92C4);
    alur_row("eq_false", isa_pkg::OP2_EQ, 4'd15, 4'd2, 4'd3, 32'h0);
    alur_row("eq_true", isa_pkg::OP2_EQ, 4'd15, 4'd2, 4'd2, 32'h1);
    alur_row("lt_neg", isa_pkg::OP2_LT, 4'd15, 4'd1, 4'd2, 32'h1);  // -5 < 0x1234
    alur_row("lt_false", isa_pkg::OP2_LT, 4'd15, 4'd2, 4'd1, 32'h0);
    alur_row("le_equal", isa_pkg::OP2_LE, 4'd15, 4'd3, 4'd3, 32'h1);
    alur_row("le_false", isa_pkg::OP2_LE, 4'd15, 4'd3, 4'd1, 32'h0);
    alur_row("ne", isa_pkg::OP2_NE, 4'd15, 4'd1, 4'd2, 32'h1);
    imm_row("addi_shamt", isa_pkg::OP1_ADDI, 4'd7, 4'd0, 16'h0004, 32'h0000_0004);
    idle_row("idle_2");
    alur_row("rshf", isa_pkg::OP2_RSHF, 4'd15, 4'd8, 4'd7, 32'hFFFF_F932);
    alur_row("lshf", isa_pkg::OP2_LSHF, 4'd14, 4'd2, 4'd7, 32'h0001_2340);
    add_row("sw_no_wb", 1'b1, enc_imm(isa_pkg::OP1_SW, 4'd5, 4'd0, 16'h0040),
            1'b0, 4'd0, 32'h0);
    imm_row("lw", isa_pkg::OP1_LW, 4'd13, 4'd0, 16'h0040, 32'hFFFF_9235);
    imm_row("lw_alias", isa_pkg::OP1_LW, 4'd12, 4'd0, 16'h0043, 32'hFFFF_9235);
    imm_row("addi_prod", isa_pkg::OP1_ADDI, 4'd10, 4'd0, 16'h0064, 32'h0000_0064);
    imm_row("addi_indep", isa_pkg::OP1_ADDI, 4'd11, 4'd0, 16'h0007, 32'h0000_0007);
    alur_row("add_dep", isa_pkg::OP2_ADD, 4'd9, 4'd10, 4'd2, 32'h0000_1298);
    add_row("bad_op1", 1'b1, enc_imm(OP1_UNUSED, 4'd1, 4'd2, 16'h0001), 1'b0, 4'd0, 32'h0);
    idle_row("idle_3");
    alur_row("bad_op2", 8'hFF, 4'd3, 4'd1, 4'd2, 32'h0);  // Unknown function writes zero
    idle_row("idle_4");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_row(input int r);
    check_value({row_name[r], " wb_valid"}, 32'(row_wb[r]), 32'(wb_valid));
    if (row_wb[r]) begin
      check_value({row_name[r], " wb_regno"}, 32'(row_reg[r]), 32'(wb_regno));
      check_value({row_name[r], " wb_data"}, row_data[r], wb_data);
    end
  endtask

  initial begin
    void'($urandom(RANDOM_SEED));
    reset      <= 1'b1;
    inst_valid <= 1'b0;
    inst       <= '0;
    build_table();
    num_rows = row_name.size();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    // Two extra cycles drain the last rows
    for (int i = 0; i < num_rows + PIPE_DEPTH; i++) begin
      @(posedge clk);
      if (i < num_rows) begin
        inst_valid <= row_valid[i];
        inst       <= row_inst[i];
      end else begin
        inst_valid <= 1'b0;
        inst       <= '0;
      end
      @(negedge clk);
      if (i >= PIPE_DEPTH) begin
        check_row(i - PIPE_DEPTH);  // Result of the row driven two edges ago
      end
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: pipe_checker.sv
module pipe_checker (
  input logic            clk,
  input logic            reset,
  input logic            inst_valid,
  input logic            wb_valid,
  input isa_pkg::regno_t wb_regno,
  input isa_pkg::word_t  wb_data
);

  // Write-back stays quiet while in reset
  wb_low_in_reset: assert property (@(posedge clk) reset |-> !wb_valid)
    else $error("wb_valid high during reset");

  // Pipeline is still empty right after release
  wb_low_after_release: assert property (
    @(posedge clk) (!reset && ($past(reset) || $past(reset, 2))) |-> !wb_valid
  ) else $error("wb_valid high within two cycles of reset release");

  wb_fields_known: assert property (
    @(posedge clk) disable iff (reset)
    wb_valid |-> (!$isunknown(wb_regno) && !$isunknown(wb_data))
  ) else $error("wb_regno or wb_data unknown while wb_valid is high");

  // Fixed two-cycle latency from inst_valid
  wb_follows_inst: assert property (
    @(posedge clk) disable iff (reset) wb_valid |-> $past(inst_valid, 2)
  ) else $error("wb_valid without an instruction two cycles earlier");

endmodule

bind pipe_top pipe_checker i_pipe_checker (
  .clk        (clk),
  .reset      (reset),
  .inst_valid (inst_valid),
  .wb_valid   (wb_valid),
  .wb_regno   (wb_regno),
  .wb_data    (wb_data)
);

// File: pipe_top.sv
module pipe_top #(
  parameter int DMEM_ADDR_BITS = 10
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            inst_valid,
  input  isa_pkg::word_t  inst,
  output logic            wb_valid,
  output isa_pkg::regno_t wb_regno,
  output isa_pkg::word_t  wb_data
);

  // Decode side
  isa_pkg::regno_t    rs;
  isa_pkg::regno_t    rt;
  isa_pkg::word_t     rs_val;
  isa_pkg::word_t     rt_val;
  logic               dec_valid;
  isa_pkg::op1_t      op1;
  isa_pkg::op2_t      op2;
  isa_pkg::word_t     sxt_imm;
  isa_pkg::regno_t    wr_regno;
  ctrl_pkg::alu_src_t alu_src;
  ctrl_pkg::wr_src_t  wr_src;
  logic               reg_we;
  logic               mem_we;

  // Execute side
  logic               ex_valid;
  isa_pkg::op1_t      ex_op1;
  isa_pkg::op2_t      ex_op2;
  isa_pkg::word_t     ex_rs_val;
  isa_pkg::word_t     ex_rt_val;
  isa_pkg::word_t     ex_sxt_imm;
  isa_pkg::regno_t    ex_wr_regno;
  ctrl_pkg::alu_src_t ex_alu_src;
  ctrl_pkg::wr_src_t  ex_wr_src;
  logic               ex_reg_we;
  logic               ex_mem_we;

  inst_decoder i_inst_decoder (
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs         (rs),
    .rt         (rt),
    .rs_val     (rs_val),
    .rt_val     (rt_val),
    .dec_valid  (dec_valid),
    .op1        (op1),
    .op2        (op2),
    .sxt_imm    (sxt_imm),
    .wr_regno   (wr_regno),
    .alu_src    (alu_src),
    .wr_src     (wr_src),
    .reg_we     (reg_we),
    .mem_we     (mem_we)
  );

  // Written back from the execute register
  reg_file i_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs       (rs),
    .rt       (rt),
    .rs_val   (rs_val),
    .rt_val   (rt_val),
    .we       (wb_valid),
    .wr_regno (wb_regno),
    .wr_data  (wb_data)
  );

  id_ex_buffer i_id_ex_buffer (
    .clk         (clk),
    .reset       (reset),
    .dec_valid   (dec_valid),
    .op1         (op1),
    .op2         (op2),
    .rs_val      (rs_val),
    .rt_val      (rt_val),
    .sxt_imm     (sxt_imm),
    .wr_regno    (wr_regno),
    .alu_src     (alu_src),
    .wr_src      (wr_src),
    .reg_we      (reg_we),
    .mem_we      (mem_we),
    .ex_valid    (ex_valid),
    .ex_op1      (ex_op1),
    .ex_op2      (ex_op2),
    .ex_rs_val   (ex_rs_val),
    .ex_rt_val   (ex_rt_val),
    .ex_sxt_imm  (ex_sxt_imm),
    .ex_wr_regno (ex_wr_regno),
    .ex_alu_src  (ex_alu_src),
    .ex_wr_src   (ex_wr_src),
    .ex_reg_we   (ex_reg_we),
    .ex_mem_we   (ex_mem_we)
  );

  alu_execute #(
    .DMEM_ADDR_BITS (DMEM_ADDR_BITS)
  ) i_alu_execute (
    .clk         (clk),
    .reset       (reset),
    .ex_valid    (ex_valid),
    .ex_op1      (ex_op1),
    .ex_op2      (ex_op2),
    .ex_rs_val   (ex_rs_val),
    .ex_rt_val   (ex_rt_val),
    .ex_sxt_imm  (ex_sxt_imm),
    .ex_wr_regno (ex_wr_regno),
    .ex_alu_src  (ex_alu_src),
    .ex_wr_src   (ex_wr_src),
    .ex_reg_we   (ex_reg_we),
    .ex_mem_we   (ex_mem_we),
    .wb_valid    (wb_valid),
    .wb_regno    (wb_regno),
    .wb_data     (wb_data)
  );

endmodule

// File: alu_execute.sv
module alu_execute #(
  parameter int DMEM_ADDR_BITS = 10
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               ex_valid,
  input  isa_pkg::op1_t      ex_op1,
  input  isa_pkg::op2_t      ex_op2,
  input  isa_pkg::word_t     ex_rs_val,
  input  isa_pkg::word_t     ex_rt_val,
  input  isa_pkg::word_t     ex_sxt_imm,
  input  isa_pkg::regno_t    ex_wr_regno,
  input  ctrl_pkg::alu_src_t ex_alu_src,
  input  ctrl_pkg::wr_src_t  ex_wr_src,
  input  logic               ex_reg_we,
  input  logic               ex_mem_we,
  output logic               wb_valid,
  output isa_pkg::regno_t    wb_regno,
  output isa_pkg::word_t     wb_data
);

  localparam int DMEM_WORDS = 1 << (DMEM_ADDR_BITS - 2);

  logic signed [31:0] opa;
  logic signed [31:0] opb;
  isa_pkg::word_t     alu_out;
  isa_pkg::word_t     mem_rd_data;
  logic [DMEM_ADDR_BITS-3:0] dmem_addr;

  isa_pkg::word_t dmem [DMEM_WORDS];

  assign opa = ex_rs_val;
  assign opb = (ex_alu_src == ctrl_pkg::ALU_SRC_IMM) ? ex_sxt_imm : ex_rt_val;

  // Signed ALU
  always_comb begin
    alu_out = '0;
    case (ex_op1)
      isa_pkg::OP1_ALUR: begin
        case (ex_op2)
          isa_pkg::OP2_EQ:   alu_out = {31'b0, opa == opb};
          isa_pkg::OP2_LT:   alu_out = {31'b0, opa < opb};
          isa_pkg::OP2_LE:   alu_out = {31'b0, opa <= opb};
          isa_pkg::OP2_NE:   alu_out = {31'b0, opa != opb};
          isa_pkg::OP2_ADD:  alu_out = opa + opb;
          isa_pkg::OP2_AND:  alu_out = opa & opb;
          isa_pkg::OP2_OR:   alu_out = opa | opb;
          isa_pkg::OP2_XOR:  alu_out = opa ^ opb;
          isa_pkg::OP2_SUB:  alu_out = opa - opb;
          isa_pkg::OP2_NAND: alu_out = ~(opa & opb);
          isa_pkg::OP2_NOR:  alu_out = ~(opa | opb);
          isa_pkg::OP2_NXOR: alu_out = opa ~^ opb;
          isa_pkg::OP2_RSHF: alu_out = opa >>> opb;  // Sign fill
          isa_pkg::OP2_LSHF: alu_out = opa << opb;
          default:           alu_out = '0;  // Unknown op2 writes zero
        endcase
      end
      isa_pkg::OP1_LW,
      isa_pkg::OP1_SW,
      isa_pkg::OP1_ADDI: alu_out = opa + opb;  // Also the memory address
      isa_pkg::OP1_ANDI: alu_out = opa & opb;
      isa_pkg::OP1_ORI:  alu_out = opa | opb;
      isa_pkg::OP1_XORI: alu_out = opa ^ opb;
      default:           alu_out = '0;
    endcase
  end

  // Word-addressed data memory, low two byte bits dropped
  assign dmem_addr   = alu_out[DMEM_ADDR_BITS-1:2];
  assign mem_rd_data = dmem[dmem_addr];

  always_ff @(posedge clk) begin
    if (ex_mem_we) begin
      dmem[dmem_addr] <= ex_rt_val;
    end
  end

  // Write-back register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_valid <= 1'b0;
      wb_regno <= '0;
      wb_data  <= '0;
    end else begin
      wb_valid <= ex_reg_we;
      if (ex_valid) begin  // Hold last result across idle cycles
        wb_regno <= ex_wr_regno;
        wb_data  <= (ex_wr_src == ctrl_pkg::WR_SRC_MEM) ? mem_rd_data : alu_out;
      end
    end
  end

endmodule

// File: id_ex_buffer.sv
module id_ex_buffer (
  input  logic               clk,
  input  logic               reset,
  input  logic               dec_valid,
  input  isa_pkg::op1_t      op1,
  input  isa_pkg::op2_t      op2,
  input  isa_pkg::word_t     rs_val,
  input  isa_pkg::word_t     rt_val,
  input  isa_pkg::word_t     sxt_imm,
  input  isa_pkg::regno_t    wr_regno,
  input  ctrl_pkg::alu_src_t alu_src,
  input  ctrl_pkg::wr_src_t  wr_src,
  input  logic               reg_we,
  input  logic               mem_we,
  output logic               ex_valid,
  output isa_pkg::op1_t      ex_op1,
  output isa_pkg::op2_t      ex_op2,
  output isa_pkg::word_t     ex_rs_val,
  output isa_pkg::word_t     ex_rt_val,
  output isa_pkg::word_t     ex_sxt_imm,
  output isa_pkg::regno_t    ex_wr_regno,
  output ctrl_pkg::alu_src_t ex_alu_src,
  output ctrl_pkg::wr_src_t  ex_wr_src,
  output logic               ex_reg_we,
  output logic               ex_mem_we
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_valid    <= 1'b0;
      ex_op1      <= '0;
      ex_op2      <= '0;
      ex_rs_val   <= '0;
      ex_rt_val   <= '0;
      ex_sxt_imm  <= '0;
      ex_wr_regno <= '0;
      ex_alu_src  <= ctrl_pkg::ALU_SRC_REG;
      ex_wr_src   <= ctrl_pkg::WR_SRC_ALU;
      ex_reg_we   <= 1'b0;
      ex_mem_we   <= 1'b0;
    end else begin
      ex_valid    <= dec_valid;
      ex_op1      <= op1;
      ex_op2      <= op2;
      ex_rs_val   <= rs_val;
      ex_rt_val   <= rt_val;
      ex_sxt_imm  <= sxt_imm;
      ex_wr_regno <= wr_regno;
      ex_alu_src  <= alu_src;
      ex_wr_src   <= wr_src;
      ex_reg_we   <= reg_we & dec_valid;  // Idle cycle writes nothing
      ex_mem_we   <= mem_we & dec_valid;
    end
  end

endmodule

// File: reg_file.sv
module reg_file (
  input  logic            clk,
  input  logic            reset,
  input  isa_pkg::regno_t rs,
  input  isa_pkg::regno_t rt,
  output isa_pkg::word_t  rs_val,
  output isa_pkg::word_t  rt_val,
  input  logic            we,
  input  isa_pkg::regno_t wr_regno,
  input  isa_pkg::word_t  wr_data
);

  localparam int NUM_REGS = 1 << $bits(isa_pkg::regno_t);

  isa_pkg::word_t regs [NUM_REGS];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_regno] <= wr_data;
    end
  end

  // Write-through so a same-cycle read sees the value being written
  assign rs_val = (we && (wr_regno == rs)) ? wr_data : regs[rs];
  assign rt_val = (we && (wr_regno == rt)) ? wr_data : regs[rt];

endmodule

// File: inst_decoder.sv
module inst_decoder (
  input  logic               inst_valid,
  input  isa_pkg::word_t     inst,
  output isa_pkg::regno_t    rs,
  output isa_pkg::regno_t    rt,
  input  isa_pkg::word_t     rs_val,
  input  isa_pkg::word_t     rt_val,
  output logic               dec_valid,
  output isa_pkg::op1_t      op1,
  output isa_pkg::op2_t      op2,
  output isa_pkg::word_t     sxt_imm,
  output isa_pkg::regno_t    wr_regno,
  output ctrl_pkg::alu_src_t alu_src,
  output ctrl_pkg::wr_src_t  wr_src,
  output logic               reg_we,
  output logic               mem_we
);

  isa_pkg::imm_t      imm;
  isa_pkg::regno_t    rd;
  ctrl_pkg::dst_sel_t dst_sel;

  // Field extraction
  assign op1 = inst[isa_pkg::OP1_HI:isa_pkg::OP1_LO];
  assign op2 = inst[isa_pkg::OP2_HI:isa_pkg::OP2_LO];
  assign imm = inst[isa_pkg::IMM_HI:isa_pkg::IMM_LO];
  assign rd  = inst[isa_pkg::RD_HI:isa_pkg::RD_LO];
  assign rs  = inst[isa_pkg::RS_HI:isa_pkg::RS_LO];
  assign rt  = inst[isa_pkg::RT_HI:isa_pkg::RT_LO];

  assign dec_valid = inst_valid;
  assign sxt_imm   = {{($bits(isa_pkg::word_t) - $bits(isa_pkg::imm_t)){imm[15]}}, imm};

  // Destination picked by the control table
  assign wr_regno = (dst_sel == ctrl_pkg::DST_RD) ? rd : rt;

  // Control table of the kept opcodes
  always_comb begin
    alu_src = ctrl_pkg::ALU_SRC_IMM;
    wr_src  = ctrl_pkg::WR_SRC_ALU;
    dst_sel = ctrl_pkg::DST_RT;
    reg_we  = 1'b0;
    mem_we  = 1'b0;
    case (op1)
      isa_pkg::OP1_ALUR: begin
        alu_src = ctrl_pkg::ALU_SRC_REG;
        dst_sel = ctrl_pkg::DST_RD;
        reg_we  = 1'b1;
      end
      isa_pkg::OP1_LW: begin
        wr_src = ctrl_pkg::WR_SRC_MEM;
        reg_we = 1'b1;
      end
      isa_pkg::OP1_SW: begin
        mem_we = 1'b1;  // Stores rt at rs plus the immediate
      end
      isa_pkg::OP1_ADDI,
      isa_pkg::OP1_ANDI,
      isa_pkg::OP1_ORI,
      isa_pkg::OP1_XORI: begin
        reg_we = 1'b1;
      end
      default: begin
        // Unknown opcode behaves as a no-op
        reg_we = 1'b0;
        mem_we = 1'b0;
      end
    endcase
  end

endmodule

// File: ctrl_pkg.sv
package ctrl_pkg;

  // Second ALU operand
  typedef logic alu_src_t;
  localparam alu_src_t ALU_SRC_REG = 1'b0;  // rt contents
  localparam alu_src_t ALU_SRC_IMM = 1'b1;  // Sign-extended immediate

  // Write-back value
  typedef logic wr_src_t;
  localparam wr_src_t WR_SRC_ALU = 1'b0;
  localparam wr_src_t WR_SRC_MEM = 1'b1;

  // Destination register field
  typedef logic dst_sel_t;
  localparam dst_sel_t DST_RT = 1'b0;
  localparam dst_sel_t DST_RD = 1'b1;

endpackage

// File: isa_pkg.sv
package isa_pkg;

  // Word and field types
  typedef logic [31:0] word_t;   // Data or instruction word
  typedef logic [3:0]  regno_t;  // Register number
  typedef logic [5:0]  op1_t;    // Primary opcode
  typedef logic [7:0]  op2_t;    // Secondary opcode
  typedef logic [15:0] imm_t;    // Immediate field

  // Primary opcodes
  localparam op1_t OP1_ALUR = 6'b000000;
  localparam op1_t OP1_LW   = 6'b010010;
  localparam op1_t OP1_SW   = 6'b011010;
  localparam op1_t OP1_ADDI = 6'b100000;
  localparam op1_t OP1_ANDI = 6'b100100;
  localparam op1_t OP1_ORI  = 6'b100101;
  localparam op1_t OP1_XORI = 6'b100110;

  // Secondary opcodes, only meaningful under OP1_ALUR
  localparam op2_t OP2_EQ   = 8'b00001000;
  localparam op2_t OP2_LT   = 8'b00001001;
  localparam op2_t OP2_LE   = 8'b00001010;
  localparam op2_t OP2_NE   = 8'b00001011;
  localparam op2_t OP2_ADD  = 8'b00100000;
  localparam op2_t OP2_AND  = 8'b00100100;
  localparam op2_t OP2_OR   = 8'b00100101;
  localparam op2_t OP2_XOR  = 8'b00100110;
  localparam op2_t OP2_SUB  = 8'b00101000;
  localparam op2_t OP2_NAND = 8'b00101100;
  localparam op2_t OP2_NOR  = 8'b00101101;
  localparam op2_t OP2_NXOR = 8'b00101110;
  localparam op2_t OP2_RSHF = 8'b00110000;
  localparam op2_t OP2_LSHF = 8'b00110001;

  // Field positions within the instruction word
  localparam int OP1_HI = 31;
  localparam int OP1_LO = 26;
  localparam int OP2_HI = 25;
  localparam int OP2_LO = 18;
  localparam int IMM_HI = 23;  // Overlaps op2 and rd
  localparam int IMM_LO = 8;
  localparam int RD_HI  = 11;
  localparam int RD_LO  = 8;
  localparam int RS_HI  = 7;
  localparam int RS_LO  = 4;
  localparam int RT_HI  = 3;
  localparam int RT_LO  = 0;

endpackage
